// ==== logic/cbus_pkg.sv ====
package cbus_pkg;

	// ##########################################################################
	// Width types

	typedef logic [63:0] addr_t;
	typedef logic [63:0] word_t;
	typedef logic [7:0]  strobe_t;
	typedef logic [3:0]  axi_id_t;
	typedef logic [7:0]  beats_t;    // Burst length minus one, as AXI len
	typedef logic [2:0]  size_t;     // Log2 of bytes per beat

	typedef enum logic [1:0] {
		INCR = 2'd1,
		WRAP = 2'd2
	} burst_e;

	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2
	} resp_e;

	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_DATA,
		WRITE_ADDR,
		WRITE_DATA,
		WRITE_RESP
	} cbus_state_e;

	// ##########################################################################
	// Cache bus

	typedef struct packed {
		logic    valid;
		logic    is_write;
		size_t   size;
		addr_t   addr;
		strobe_t strobe;
		word_t   data;
		beats_t  len;
		burst_e  burst;
	} cbus_req_t;

	typedef struct packed {
		logic  ready;
		logic  last;
		logic  error;    // Meaningful with last only
		word_t data;
	} cbus_resp_t;

	// ##########################################################################
	// AXI4 channel payloads

	typedef struct packed {
		axi_id_t    id;
		addr_t      addr;
		beats_t     len;
		size_t      size;
		burst_e     burst;
		logic       lock;
		logic [3:0] cache;
		logic [2:0] prot;
	} axi_addr_t;

	typedef struct packed {
		word_t   data;
		strobe_t strobe;
		logic    last;
	} axi_w_t;

	typedef struct packed {
		axi_id_t id;
		word_t   data;
		resp_e   resp;
		logic    last;
	} axi_r_t;

	typedef struct packed {
		axi_id_t id;
		resp_e   resp;
	} axi_b_t;

endpackage

// ==== logic/cbus_arbiter.sv ====
module cbus_arbiter (
	input  logic                  aclk,
	input  logic                  rst_n,

	input  cbus_pkg::cbus_req_t   ireq,
	output cbus_pkg::cbus_resp_t  iresp,
	input  cbus_pkg::cbus_req_t   dreq,
	output cbus_pkg::cbus_resp_t  dresp,

	output cbus_pkg::cbus_req_t   greq,
	input  cbus_pkg::cbus_resp_t  gresp
);

	logic busy_q;
	logic owner_q;       // 1 selects the data port
	logic grant_d;
	logic any_valid;
	logic done;

	// ##########################################################################
	// Grant decision

	assign any_valid = ireq.valid | dreq.valid;
	assign grant_d   = dreq.valid;    // Data port wins a tie
	assign done      = busy_q & gresp.ready & gresp.last;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			busy_q  <= 1'b0;
			owner_q <= 1'b0;
		end else begin
			if (!busy_q) begin
				if (any_valid) begin
					busy_q  <= 1'b1;
					owner_q <= grant_d;
				end
			end else if (done) begin
				busy_q <= 1'b0;    // Free again next cycle
			end
		end
	end

	// ##########################################################################
	// Request forward and response steering

	always_comb begin
		greq = '0;
		if (busy_q) begin
			greq = owner_q ? dreq : ireq;
		end
	end

	always_comb begin
		iresp = '0;
		dresp = '0;
		if (busy_q) begin
			if (owner_q) begin
				dresp = gresp;
			end else begin
				iresp = gresp;
			end
		end
	end

endmodule

// ==== logic/cbus_to_axi.sv ====
module cbus_to_axi #(
	parameter cbus_pkg::axi_id_t AXI_ID = '0
) (
	input  logic                  aclk,
	input  logic                  rst_n,

	input  cbus_pkg::cbus_req_t   req,
	output cbus_pkg::cbus_resp_t  resp,

	output cbus_pkg::axi_addr_t   ar,
	output logic                  arvalid,
	input  logic                  arready,
	input  cbus_pkg::axi_r_t      r,
	input  logic                  rvalid,
	output logic                  rready,

	output cbus_pkg::axi_addr_t   aw,
	output logic                  awvalid,
	input  logic                  awready,
	output cbus_pkg::axi_w_t      w,
	output logic                  wvalid,
	input  logic                  wready,
	input  cbus_pkg::axi_b_t      b,
	input  logic                  bvalid,
	output logic                  bready
);

	cbus_pkg::cbus_state_e state_q;
	cbus_pkg::cbus_state_e state_d;
	cbus_pkg::beats_t      beat_q;    // W beats already accepted
	cbus_pkg::axi_addr_t   addr_req;
	logic                  err_q;
	logic                  r_bad;
	logic                  w_last;

	// ##########################################################################
	// Address and write payloads from the held request

	always_comb begin
		addr_req       = '0;
		addr_req.id    = AXI_ID;
		addr_req.addr  = req.addr;
		addr_req.len   = req.len;
		addr_req.size  = req.size;
		addr_req.burst = req.burst;
		addr_req.lock  = 1'b0;
		addr_req.cache = 4'b0011;    // Normal, bufferable
		addr_req.prot  = 3'b000;
	end

	assign ar = addr_req;
	assign aw = addr_req;

	assign w_last   = (beat_q == req.len);
	assign w.data   = req.data;
	assign w.strobe = req.strobe;
	assign w.last   = w_last;

	assign r_bad = (r.resp != cbus_pkg::OKAY);

	// ##########################################################################
	// State machine

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			cbus_pkg::IDLE: begin
				if (req.valid) begin
					state_d = req.is_write ? cbus_pkg::WRITE_ADDR : cbus_pkg::READ_ADDR;
				end
			end
			cbus_pkg::READ_ADDR: begin
				if (arready) state_d = cbus_pkg::READ_DATA;
			end
			cbus_pkg::READ_DATA: begin
				if (rvalid && r.last) state_d = cbus_pkg::IDLE;
			end
			cbus_pkg::WRITE_ADDR: begin
				if (awready) state_d = cbus_pkg::WRITE_DATA;
			end
			cbus_pkg::WRITE_DATA: begin
				if (wready && w_last) state_d = cbus_pkg::WRITE_RESP;
			end
			cbus_pkg::WRITE_RESP: begin
				if (bvalid) state_d = cbus_pkg::IDLE;
			end
			default: state_d = cbus_pkg::IDLE;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state_q <= cbus_pkg::IDLE;
			beat_q  <= '0;
			err_q   <= 1'b0;
		end else begin
			state_q <= state_d;

			if (state_q == cbus_pkg::IDLE) begin
				err_q <= 1'b0;
			end else if (rvalid && rready && r_bad) begin
				err_q <= 1'b1;    // Sticky until next request
			end

			if (awvalid && awready) begin
				beat_q <= '0;
			end else if (wvalid && wready) begin
				beat_q <= beat_q + cbus_pkg::beats_t'(1);
			end
		end
	end

	// ##########################################################################
	// Channel handshakes and cbus response

	assign arvalid = (state_q == cbus_pkg::READ_ADDR);
	assign awvalid = (state_q == cbus_pkg::WRITE_ADDR);
	assign wvalid  = (state_q == cbus_pkg::WRITE_DATA);
	assign rready  = (state_q == cbus_pkg::READ_DATA);
	assign bready  = (state_q == cbus_pkg::WRITE_RESP);

	always_comb begin
		resp = '0;
		unique case (state_q)
			cbus_pkg::READ_DATA: begin
				resp.ready = rvalid;            // Beat passes straight through
				resp.last  = r.last;
				resp.data  = r.data;
				resp.error = r.last & (err_q | r_bad);
			end
			cbus_pkg::WRITE_DATA: begin
				resp.ready = wready & ~w_last;  // Final ack comes from B
			end
			cbus_pkg::WRITE_RESP: begin
				resp.ready = bvalid;
				resp.last  = 1'b1;
				resp.error = (b.resp != cbus_pkg::OKAY);
			end
			default: resp = '0;
		endcase
	end

endmodule

// ==== logic/mem_bridge_top.sv ====
module mem_bridge_top #(
	parameter cbus_pkg::axi_id_t AXI_ID = '0
) (
	input  logic                  aclk,
	input  logic                  rst_n,

	input  cbus_pkg::cbus_req_t   ireq,
	output cbus_pkg::cbus_resp_t  iresp,
	input  cbus_pkg::cbus_req_t   dreq,
	output cbus_pkg::cbus_resp_t  dresp,

	output cbus_pkg::axi_addr_t   ar,
	output logic                  arvalid,
	input  logic                  arready,
	input  cbus_pkg::axi_r_t      r,
	input  logic                  rvalid,
	output logic                  rready,

	output cbus_pkg::axi_addr_t   aw,
	output logic                  awvalid,
	input  logic                  awready,
	output cbus_pkg::axi_w_t      w,
	output logic                  wvalid,
	input  logic                  wready,
	input  cbus_pkg::axi_b_t      b,
	input  logic                  bvalid,
	output logic                  bready
);

	cbus_pkg::cbus_req_t  greq;    // Granted request
	cbus_pkg::cbus_resp_t gresp;

	cbus_arbiter u_arbiter (
		.aclk  (aclk),
		.rst_n (rst_n),
		.ireq  (ireq),
		.iresp (iresp),
		.dreq  (dreq),
		.dresp (dresp),
		.greq  (greq),
		.gresp (gresp)
	);

	cbus_to_axi #(
		.AXI_ID (AXI_ID)
	) u_cvt (
		.aclk    (aclk),
		.rst_n   (rst_n),
		.req     (greq),
		.resp    (gresp),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready)
	);

endmodule

// ==== verification/axi_mem_model.sv ====
module axi_mem_model (
	input  logic                 aclk,
	input  logic                 rst_n,

	input  cbus_pkg::axi_addr_t  ar,
	input  logic                 arvalid,
	output logic                 arready,
	output cbus_pkg::axi_r_t     r,
	output logic                 rvalid,
	input  logic                 rready,

	input  cbus_pkg::axi_addr_t  aw,
	input  logic                 awvalid,
	output logic                 awready,
	input  cbus_pkg::axi_w_t     w,
	input  logic                 wvalid,
	output logic                 wready,
	output cbus_pkg::axi_b_t     b,
	output logic                 bvalid,
	input  logic                 bready
);

	cbus_pkg::word_t     mem [256];    // Word index is addr[10:3]
	cbus_pkg::axi_addr_t rd_cmd;       // Address field advances per beat
	cbus_pkg::axi_addr_t wr_cmd;
	cbus_pkg::beats_t    rd_left;
	logic                rd_act;
	logic                wr_err;
	cbus_pkg::word_t     wmask;

	assign wmask = {{8{w.strobe[7]}}, {8{w.strobe[6]}}, {8{w.strobe[5]}}, {8{w.strobe[4]}},
	                {8{w.strobe[3]}}, {8{w.strobe[2]}}, {8{w.strobe[1]}}, {8{w.strobe[0]}}};

	function automatic cbus_pkg::addr_t next_addr(input cbus_pkg::axi_addr_t c);
		cbus_pkg::addr_t step;
		cbus_pkg::addr_t span;
		step = 64'd1 << c.size;
		span = (64'(c.len) + 64'd1) << c.size;    // Wrap block in bytes
		if (c.burst == cbus_pkg::WRAP) begin
			next_addr = (c.addr & ~(span - 64'd1)) | ((c.addr + step) & (span - 64'd1));
		end else begin
			next_addr = c.addr + step;
		end
	endfunction

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) begin
				mem[8'(i)] <= {~32'(i), 32'(i) * 32'h0101_0101};
			end
			arready <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			rvalid  <= 1'b0;
			bvalid  <= 1'b0;
			rd_act  <= 1'b0;
			rd_left <= '0;
			rd_cmd  <= '0;
			wr_cmd  <= '0;
			wr_err  <= 1'b0;
			r       <= '0;
			b       <= '0;
		end else begin
			arready <= ($urandom % 3) != 0;    // Random stalls
			awready <= ($urandom % 3) != 0;
			wready  <= ($urandom % 4) != 0;

			// ##################################################################
			// Read side
			if (arvalid && arready) begin
				rd_cmd  <= ar;
				rd_left <= ar.len;
				rd_act  <= 1'b1;
			end
			if (rvalid && rready) begin
				rvalid      <= 1'b0;
				rd_cmd.addr <= next_addr(rd_cmd);
				rd_left     <= rd_left - 8'd1;
				rd_act      <= !r.last;
			end else if (rd_act && !rvalid && ($urandom % 2) == 0) begin
				rvalid <= 1'b1;
				r.id   <= rd_cmd.id;
				r.data <= mem[rd_cmd.addr[10:3]];
				r.resp <= rd_cmd.addr[40] ? cbus_pkg::SLVERR : cbus_pkg::OKAY;
				r.last <= (rd_left == 8'd0);
			end

			// ##################################################################
			// Write side
			if (awvalid && awready) begin
				wr_cmd <= aw;
				wr_err <= aw.addr[40];    // Error region, nothing stored
			end
			if (wvalid && wready) begin
				if (!wr_err) begin
					mem[wr_cmd.addr[10:3]] <= (mem[wr_cmd.addr[10:3]] & ~wmask) | (w.data & wmask);
				end
				wr_cmd.addr <= next_addr(wr_cmd);
				if (w.last) begin
					bvalid <= 1'b1;
					b.id   <= wr_cmd.id;
					b.resp <= wr_err ? cbus_pkg::SLVERR : cbus_pkg::OKAY;
				end
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

endmodule

// ==== verification/bridge_assert.sv ====
module bridge_assert (
	input  logic                  aclk,
	input  logic                  rst_n,
	input  cbus_pkg::cbus_state_e state,
	input  cbus_pkg::axi_addr_t   ar,
	input  logic                  arvalid,
	input  logic                  arready,
	input  cbus_pkg::axi_addr_t   aw,
	input  logic                  awvalid,
	input  logic                  awready,
	input  cbus_pkg::axi_w_t      w,
	input  logic                  wvalid,
	input  logic                  wready
);

	int unsigned fail_cnt = 0;    // Read by the testbench at the end

	ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(ar))
		else begin
			$error("AR valid or payload changed before arready");
			fail_cnt = fail_cnt + 1;
		end

	aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(aw))
		else begin
			$error("AW valid or payload changed before awready");
			fail_cnt = fail_cnt + 1;
		end

	w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		state == cbus_pkg::WRITE_DATA && !wready |=> wvalid && $stable(w))
		else begin
			$error("W valid or payload changed before wready");
			fail_cnt = fail_cnt + 1;
		end

endmodule

bind cbus_to_axi bridge_assert u_assert (
	.aclk    (aclk),
	.rst_n   (rst_n),
	.state   (state_q),
	.ar      (ar),
	.arvalid (arvalid),
	.arready (arready),
	.aw      (aw),
	.awvalid (awvalid),
	.awready (awready),
	.w       (w),
	.wvalid  (wvalid),
	.wready  (wready)
);

// ==== verification/bridge_tb.sv ====
module bridge_tb;

	localparam int CYCLE      = 40;
	localparam int TEST_BEATS = 28;    // cbus beats over all six tests
	localparam cbus_pkg::axi_id_t BUS_ID = 4'd5;

	logic                 aclk;
	logic                 rst_n;
	cbus_pkg::cbus_req_t  ireq;
	cbus_pkg::cbus_resp_t iresp;
	cbus_pkg::cbus_req_t  dreq;
	cbus_pkg::cbus_resp_t dresp;
	cbus_pkg::axi_addr_t  ar;
	logic                 arvalid;
	logic                 arready;
	cbus_pkg::axi_r_t     r;
	logic                 rvalid;
	logic                 rready;
	cbus_pkg::axi_addr_t  aw;
	logic                 awvalid;
	logic                 awready;
	cbus_pkg::axi_w_t     w;
	logic                 wvalid;
	logic                 wready;
	cbus_pkg::axi_b_t     b;
	logic                 bvalid;
	logic                 bready;

	cbus_pkg::word_t      wr_data [2][16];    // Port 0 instr, port 1 data
	cbus_pkg::word_t      got     [2][16];
	logic                 got_err [2];
	time                  done_at [2];
	cbus_pkg::word_t      kept_word;
	int                   value_errs;
	int                   other_errs;

	mem_bridge_top #(.AXI_ID(BUS_ID)) uut (.*);

	axi_mem_model u_mem (.*);

	initial begin
		aclk = 1'b0;
		forever #(CYCLE / 2) aclk = ~aclk;
	end

	initial begin
		#(TEST_BEATS * 200 * CYCLE);
		$display("Timeout: tests did not finish within %0d cycles", TEST_BEATS * 200);
		$display("Checks failed");
		$finish;
	end

	// ##########################################################################
	// Compare helpers

	task automatic check_word(input string name, input cbus_pkg::word_t got_v,
			input cbus_pkg::word_t exp_v);
		if (got_v !== exp_v) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got_v, exp_v);
			value_errs++;
		end
	endtask

	task automatic check_error(input string name, input logic got_v, input logic exp_v);
		if (got_v !== exp_v) begin
			$display("ERR %0t %s got %b exp %b", $time, name, got_v, exp_v);
			value_errs++;
		end
	endtask

	task automatic check_id(input string name, input cbus_pkg::axi_id_t got_v,
			input cbus_pkg::axi_id_t exp_v);
		if (got_v !== exp_v) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got_v, exp_v);
			value_errs++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%0t %s", $time, msg);
		other_errs++;
	endtask

	function automatic cbus_pkg::word_t rand_word();
		return {$urandom, $urandom};
	endfunction

	// Every address request carries the configured ID
	always @(posedge aclk) begin
		if (arvalid) begin
			check_id("ar.id", ar.id, BUS_ID);
		end
		if (awvalid) begin
			check_id("aw.id", aw.id, BUS_ID);
		end
	end

	// ##########################################################################
	// Requester tasks

	task automatic drive_req(input bit dport, input cbus_pkg::cbus_req_t req);
		if (dport) begin
			dreq <= req;
		end else begin
			ireq <= req;
		end
	endtask

	task automatic cbus_read(input bit dport, input cbus_pkg::addr_t addr,
			input cbus_pkg::beats_t len, input cbus_pkg::burst_e burst);
		cbus_pkg::cbus_req_t  req;
		cbus_pkg::cbus_resp_t rsp;
		logic [4:0]           beat;
		beat      = 5'd0;
		req       = '0;
		req.valid = 1'b1;
		req.size  = 3'd3;
		req.addr  = addr;
		req.len   = len;
		req.burst = burst;
		drive_req(dport, req);
		do begin
			@(posedge aclk);
			rsp = dport ? dresp : iresp;
			if (rsp.ready) begin
				got[dport][beat[3:0]] = rsp.data;
				check_error($sformatf("last[%0d]", beat), rsp.last, {3'd0, beat} == len);
				beat = beat + 5'd1;
			end
		end while (!(rsp.ready && rsp.last));
		if ({3'd0, beat} != len + 8'd1) begin
			report_failure("read burst returned the wrong number of beats");
		end
		got_err[dport] = rsp.error;
		done_at[dport] = $time;
		drive_req(dport, '0);
		@(posedge aclk);
	endtask

	task automatic cbus_write(input bit dport, input cbus_pkg::addr_t addr,
			input cbus_pkg::beats_t len, input cbus_pkg::strobe_t strobe);
		cbus_pkg::cbus_req_t  req;
		cbus_pkg::cbus_resp_t rsp;
		logic [4:0]           beat;
		beat         = 5'd0;
		req          = '0;
		req.valid    = 1'b1;
		req.is_write = 1'b1;
		req.size     = 3'd3;
		req.addr     = addr;
		req.strobe   = strobe;
		req.data     = wr_data[dport][0];
		req.len      = len;
		req.burst    = cbus_pkg::INCR;
		drive_req(dport, req);
		do begin
			@(posedge aclk);
			rsp = dport ? dresp : iresp;
			if (rsp.ready && !rsp.last) begin
				beat     = beat + 5'd1;    // Next beat goes out this edge
				req.data = wr_data[dport][beat[3:0]];
				drive_req(dport, req);
			end
		end while (!(rsp.ready && rsp.last));
		if ({3'd0, beat} != len) begin
			report_failure("write burst acknowledged the wrong number of beats");
		end
		got_err[dport] = rsp.error;
		drive_req(dport, '0);
		@(posedge aclk);
	endtask

	// ##########################################################################
	// Directed tests

	task automatic single_write_read();
		kept_word     = rand_word();
		wr_data[1][0] = kept_word;
		cbus_write(1'b1, 64'h40, 8'd0, 8'hff);
		check_error("single write error", got_err[1], 1'b0);
		cbus_read(1'b1, 64'h40, 8'd0, cbus_pkg::INCR);
		check_word("single rdata", got[1][0], kept_word);
	endtask

	task automatic incr_burst();
		for (int i = 0; i < 4; i++) begin
			wr_data[1][4'(i)] = rand_word();
		end
		cbus_write(1'b1, 64'h100, 8'd3, 8'hff);
		check_error("burst write error", got_err[1], 1'b0);
		cbus_read(1'b1, 64'h100, 8'd3, cbus_pkg::INCR);
		for (int i = 0; i < 4; i++) begin
			check_word($sformatf("incr rdata[%0d]", i), got[1][4'(i)], wr_data[1][4'(i)]);
		end
	endtask

	// Reads the block written by incr_burst, so it runs right after it
	task automatic wrap_read();
		cbus_read(1'b0, 64'h110, 8'd3, cbus_pkg::WRAP);
		// 32 byte block at 0x100, start at its third word
		for (int i = 0; i < 4; i++) begin
			check_word($sformatf("wrap rdata[%0d]", i), got[0][4'(i)],
				wr_data[1][4'((2 + i) % 4)]);
		end
	endtask

	task automatic strobe_merge();
		cbus_pkg::word_t old_word;
		cbus_pkg::word_t new_word;
		old_word      = rand_word();
		new_word      = rand_word();
		wr_data[1][0] = old_word;
		cbus_write(1'b1, 64'h200, 8'd0, 8'hff);
		wr_data[1][0] = new_word;
		cbus_write(1'b1, 64'h200, 8'd0, 8'h35);    // Bytes 0, 2, 4, 5
		cbus_read(1'b1, 64'h200, 8'd0, cbus_pkg::INCR);
		check_word("strobe rdata", got[1][0],
			(old_word & ~64'h0000_ffff_00ff_00ff) | (new_word & 64'h0000_ffff_00ff_00ff));
	endtask

	task automatic port_contention();
		for (int i = 0; i < 2; i++) begin
			wr_data[0][4'(i)] = rand_word();
			wr_data[1][4'(i)] = rand_word();
		end
		cbus_write(1'b1, 64'h300, 8'd1, 8'hff);
		cbus_write(1'b0, 64'h340, 8'd1, 8'hff);
		fork
			cbus_read(1'b0, 64'h340, 8'd1, cbus_pkg::INCR);
			cbus_read(1'b1, 64'h300, 8'd1, cbus_pkg::INCR);
		join
		if (done_at[1] >= done_at[0]) begin
			report_failure("instruction port finished before the data port");
		end
		for (int i = 0; i < 2; i++) begin
			check_word($sformatf("dport rdata[%0d]", i), got[1][4'(i)], wr_data[1][4'(i)]);
			check_word($sformatf("iport rdata[%0d]", i), got[0][4'(i)], wr_data[0][4'(i)]);
		end
	endtask

	task automatic error_region();
		wr_data[1][0] = rand_word();
		cbus_write(1'b1, 64'h0000_0100_0000_0080, 8'd0, 8'hff);    // Bit 40 set
		check_error("error region write", got_err[1], 1'b1);
		cbus_read(1'b1, 64'h0000_0100_0000_0080, 8'd0, cbus_pkg::INCR);
		check_error("error region read", got_err[1], 1'b1);
		cbus_read(1'b1, 64'h40, 8'd0, cbus_pkg::INCR);
		check_error("read error after error region", got_err[1], 1'b0);
		check_word("rdata after error region", got[1][0], kept_word);
	endtask

	// ##########################################################################
	// Main sequence

	initial begin
		void'($urandom(91520));
		value_errs = 0;
		other_errs = 0;
		rst_n      = 1'b0;
		ireq       = '0;
		dreq       = '0;
		repeat (5) @(posedge aclk);
		rst_n <= 1'b1;
		@(posedge aclk);

		single_write_read();
		incr_burst();
		wrap_read();
		strobe_merge();
		port_contention();
		error_region();

		$display("Errors: %0d value, %0d other, %0d assertion",
			value_errs, other_errs, uut.u_cvt.u_assert.fail_cnt);
		if (value_errs == 0 && other_errs == 0 && uut.u_cvt.u_assert.fail_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
logic/cbus_pkg.sv
logic/cbus_arbiter.sv
logic/cbus_to_axi.sv
logic/mem_bridge_top.sv
verification/axi_mem_model.sv
verification/bridge_assert.sv
verification/bridge_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vbridge_tb
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert --top-module bridge_tb -f files.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
